//--- logic/thumb_ctrl_pkg.sv
package thumb_ctrl_pkg;

    typedef logic [15:0] instr_t;
    typedef logic [3:0]  reg_addr_t;
    typedef logic [15:0] reg_list_t;
    typedef logic [31:0] word_t;

    localparam reg_addr_t SP_REG = 4'd13;
    localparam reg_addr_t LR_REG = 4'd14;

    // address step per transferred register
    localparam int WORD_BYTES = 4;

    typedef enum logic [1:0] {
        KIND_SINGLE,
        KIND_PUSH,
        KIND_STM,
        KIND_LDM
    } op_kind_e;

    // shift/add/sub/move/compare group, taken from bits 13:11
    typedef enum logic [2:0] {
        SH_LSL,
        SH_LSR,
        SH_ASR,
        SH_ADD_SUB,
        SH_MOV8,
        SH_CMP8,
        SH_ADD8,
        SH_SUB8
    } shift_op_e;

    // data-processing group, taken from bits 9:6
    typedef enum logic [3:0] {
        DP_AND, DP_EOR, DP_LSL, DP_LSR,
        DP_ASR, DP_ADC, DP_SBC, DP_ROR,
        DP_TST, DP_RSB, DP_CMP, DP_CMN,
        DP_ORR, DP_MUL, DP_BIC, DP_MVN
    } dp_op_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_BIT_CLEAR,
        ALU_NOT,
        ALU_MULT,
        ALU_ROTATE_R,
        ALU_LSL,
        ALU_LSR,
        ALU_ASR
    } alu_op_e;

    typedef enum logic [1:0] {
        SEL_REG,
        SEL_IMM,
        SEL_ZERO
    } operand_sel_e;

    typedef enum logic {
        WB_ALU,
        WB_MEM
    } wb_sel_e;

    typedef struct packed {
        logic         valid;
        alu_op_e      alu_op;
        operand_sel_e src1_sel;
        operand_sel_e src2_sel;
        wb_sel_e      wb_sel;
        logic         update_flags;
        logic         reg_we;
        logic         mem_we;
        logic         mem_re;
        reg_addr_t    rd;
        reg_addr_t    rn;
        reg_addr_t    rm;
        word_t        imm;
    } micro_op_t;

    typedef struct packed {
        op_kind_e  kind;
        micro_op_t uop;
        reg_list_t reg_list;
        reg_addr_t base;
    } decoded_op_t;

endpackage

//--- logic/thumb_decoder.sv
`timescale 1ns/1ps

module thumb_decoder (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  logic                        instr_valid_i,
    input  thumb_ctrl_pkg::instr_t      instr_i,
    output logic                        push_o,
    output thumb_ctrl_pkg::decoded_op_t push_data_o,
    output logic                        illegal_o
);

    thumb_ctrl_pkg::shift_op_e sh_op;
    thumb_ctrl_pkg::dp_op_e    dp_op;
    logic                      legal;

    assign sh_op = thumb_ctrl_pkg::shift_op_e'(instr_i[13:11]);
    assign dp_op = thumb_ctrl_pkg::dp_op_e'(instr_i[9:6]);

    always_comb begin
        push_data_o = '0;
        push_data_o.kind = thumb_ctrl_pkg::KIND_SINGLE;
        push_data_o.uop.valid = 1'b1;
        push_data_o.uop.alu_op = thumb_ctrl_pkg::ALU_ADD;
        push_data_o.uop.src1_sel = thumb_ctrl_pkg::SEL_REG;
        push_data_o.uop.src2_sel = thumb_ctrl_pkg::SEL_REG;
        push_data_o.uop.wb_sel = thumb_ctrl_pkg::WB_ALU;
        legal = 1'b1;

        casez (instr_i)
            16'b00??_????_????_????: begin
                push_data_o.uop.update_flags = 1'b1;
                push_data_o.uop.reg_we = 1'b1;
                // bit 13 marks the 8-bit immediate forms, which share rd and rn
                if (instr_i[13]) begin
                    push_data_o.uop.rd = {1'b0, instr_i[10:8]};
                    push_data_o.uop.rn = {1'b0, instr_i[10:8]};
                    push_data_o.uop.imm = thumb_ctrl_pkg::word_t'(instr_i[7:0]);
                    push_data_o.uop.src2_sel = thumb_ctrl_pkg::SEL_IMM;
                end else begin
                    push_data_o.uop.rd = {1'b0, instr_i[2:0]};
                    push_data_o.uop.rn = {1'b0, instr_i[5:3]};
                end
                case (sh_op)
                    thumb_ctrl_pkg::SH_LSL, thumb_ctrl_pkg::SH_LSR, thumb_ctrl_pkg::SH_ASR: begin
                        push_data_o.uop.alu_op = (sh_op == thumb_ctrl_pkg::SH_LSL) ?
                            thumb_ctrl_pkg::ALU_LSL : (sh_op == thumb_ctrl_pkg::SH_LSR) ?
                            thumb_ctrl_pkg::ALU_LSR : thumb_ctrl_pkg::ALU_ASR;
                        push_data_o.uop.imm = thumb_ctrl_pkg::word_t'(instr_i[10:6]);
                        push_data_o.uop.src2_sel = thumb_ctrl_pkg::SEL_IMM;
                    end
                    thumb_ctrl_pkg::SH_ADD_SUB: begin
                        // bit 10 picks the 3-bit immediate, bit 9 picks subtract
                        push_data_o.uop.alu_op = instr_i[9] ?
                            thumb_ctrl_pkg::ALU_SUB : thumb_ctrl_pkg::ALU_ADD;
                        if (instr_i[10]) begin
                            push_data_o.uop.imm = thumb_ctrl_pkg::word_t'(instr_i[8:6]);
                            push_data_o.uop.src2_sel = thumb_ctrl_pkg::SEL_IMM;
                        end else begin
                            push_data_o.uop.rm = {1'b0, instr_i[8:6]};
                        end
                    end
                    thumb_ctrl_pkg::SH_MOV8: push_data_o.uop.src1_sel = thumb_ctrl_pkg::SEL_ZERO;
                    thumb_ctrl_pkg::SH_CMP8: begin
                        push_data_o.uop.alu_op = thumb_ctrl_pkg::ALU_SUB;
                        push_data_o.uop.reg_we = 1'b0;
                    end
                    thumb_ctrl_pkg::SH_SUB8: push_data_o.uop.alu_op = thumb_ctrl_pkg::ALU_SUB;
                    default: ;
                endcase
            end
            16'b0100_00??_????_????: begin
                push_data_o.uop.update_flags = 1'b1;
                push_data_o.uop.reg_we = 1'b1;
                push_data_o.uop.rd = {1'b0, instr_i[2:0]};
                push_data_o.uop.rn = {1'b0, instr_i[2:0]};
                push_data_o.uop.rm = {1'b0, instr_i[5:3]};
                case (dp_op)
                    thumb_ctrl_pkg::DP_AND: push_data_o.uop.alu_op = thumb_ctrl_pkg::ALU_AND;
                    thumb_ctrl_pkg::DP_EOR: push_data_o.uop.alu_op = thumb_ctrl_pkg::ALU_XOR;
                    thumb_ctrl_pkg::DP_LSL: push_data_o.uop.alu_op = thumb_ctrl_pkg::ALU_LSL;
                    thumb_ctrl_pkg::DP_LSR: push_data_o.uop.alu_op = thumb_ctrl_pkg::ALU_LSR;
                    thumb_ctrl_pkg::DP_ASR: push_data_o.uop.alu_op = thumb_ctrl_pkg::ALU_ASR;
                    thumb_ctrl_pkg::DP_ADC: push_data_o.uop.alu_op = thumb_ctrl_pkg::ALU_ADD;
                    thumb_ctrl_pkg::DP_SBC: push_data_o.uop.alu_op = thumb_ctrl_pkg::ALU_SUB;
                    thumb_ctrl_pkg::DP_ROR: push_data_o.uop.alu_op = thumb_ctrl_pkg::ALU_ROTATE_R;
                    thumb_ctrl_pkg::DP_TST: begin
                        push_data_o.uop.alu_op = thumb_ctrl_pkg::ALU_AND;
                        push_data_o.uop.reg_we = 1'b0;
                    end
                    thumb_ctrl_pkg::DP_RSB: begin
                        push_data_o.uop.alu_op = thumb_ctrl_pkg::ALU_SUB;
                        push_data_o.uop.src1_sel = thumb_ctrl_pkg::SEL_ZERO;
                    end
                    thumb_ctrl_pkg::DP_CMP: begin
                        push_data_o.uop.alu_op = thumb_ctrl_pkg::ALU_SUB;
                        push_data_o.uop.reg_we = 1'b0;
                    end
                    thumb_ctrl_pkg::DP_CMN: begin
                        push_data_o.uop.reg_we = 1'b0;
                    end
                    thumb_ctrl_pkg::DP_ORR: push_data_o.uop.alu_op = thumb_ctrl_pkg::ALU_OR;
                    thumb_ctrl_pkg::DP_MUL: push_data_o.uop.alu_op = thumb_ctrl_pkg::ALU_MULT;
                    thumb_ctrl_pkg::DP_BIC: push_data_o.uop.alu_op = thumb_ctrl_pkg::ALU_BIT_CLEAR;
                    default:                push_data_o.uop.alu_op = thumb_ctrl_pkg::ALU_NOT;
                endcase
            end
            16'b1011_010?_????_????: begin
                push_data_o.kind = thumb_ctrl_pkg::KIND_PUSH;
                push_data_o.uop.alu_op = thumb_ctrl_pkg::ALU_SUB;
                push_data_o.uop.src2_sel = thumb_ctrl_pkg::SEL_IMM;
                push_data_o.reg_list[7:0] = instr_i[7:0];
                push_data_o.reg_list[thumb_ctrl_pkg::LR_REG] = instr_i[8];
                push_data_o.base = thumb_ctrl_pkg::SP_REG;
            end
            16'b1100_????_????_????: begin
                push_data_o.kind = instr_i[11] ?
                    thumb_ctrl_pkg::KIND_LDM : thumb_ctrl_pkg::KIND_STM;
                push_data_o.uop.src2_sel = thumb_ctrl_pkg::SEL_IMM;
                push_data_o.reg_list[7:0] = instr_i[7:0];
                push_data_o.base = {1'b0, instr_i[10:8]};
            end
            default: legal = 1'b0;
        endcase
    end

    assign push_o = instr_valid_i && legal;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            illegal_o <= 1'b0;
        end else begin
            illegal_o <= instr_valid_i && !legal;
        end
    end

    a_push_needs_strobe: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        push_o |-> instr_valid_i);

endmodule

//--- logic/micro_op_queue.sv
`timescale 1ns/1ps

module micro_op_queue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  logic                        push_i,
    input  thumb_ctrl_pkg::decoded_op_t push_data_i,
    input  logic                        pop_i,
    output thumb_ctrl_pkg::decoded_op_t head_o,
    output logic                        empty_o,
    output logic                        full_o
);

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    thumb_ctrl_pkg::decoded_op_t mem_q [QUEUE_DEPTH];
    logic [PTR_W-1:0]            wr_ptr_q;
    logic [PTR_W-1:0]            rd_ptr_q;
    logic [CNT_W-1:0]            count_q;
    logic                        do_push;
    logic                        do_pop;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        // the depth need not be a power of two
        return (ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign empty_o = (count_q == '0);
    assign full_o  = (count_q == CNT_W'(QUEUE_DEPTH));
    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;
    assign head_o  = mem_q[rd_ptr_q];

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= push_data_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= ptr_inc(wr_ptr_q);
            end
            if (do_pop) begin
                rd_ptr_q <= ptr_inc(rd_ptr_q);
            end
            if (do_push && !do_pop) begin
                count_q <= count_q + 1'b1;
            end else if (do_pop && !do_push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    // the decoder has no stall, so a push here would lose an instruction
    a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(push_i && full_o));

    a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(pop_i && empty_o));

endmodule

//--- logic/reg_list_sequencer.sv
`timescale 1ns/1ps

module reg_list_sequencer (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  thumb_ctrl_pkg::decoded_op_t head_i,
    input  logic                        empty_i,
    output logic                        pop_o,
    output thumb_ctrl_pkg::micro_op_t   micro_op_o
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_TRANSFER,
        ST_FINAL
    } state_e;

    state_e                    state_q;
    state_e                    state_d;
    thumb_ctrl_pkg::micro_op_t word_d;
    thumb_ctrl_pkg::op_kind_e  kind_q;
    thumb_ctrl_pkg::op_kind_e  cur_kind;
    thumb_ctrl_pkg::micro_op_t tmpl_q;
    thumb_ctrl_pkg::micro_op_t cur_tmpl;
    thumb_ctrl_pkg::reg_list_t list_q;
    thumb_ctrl_pkg::reg_list_t cur_list;
    thumb_ctrl_pkg::reg_list_t rest_list;
    thumb_ctrl_pkg::reg_addr_t base_q;
    thumb_ctrl_pkg::reg_addr_t cur_base;
    thumb_ctrl_pkg::reg_addr_t low_reg;
    logic [4:0]                k_q;
    logic [4:0]                cur_k;
    logic [4:0]                n_q;
    logic [4:0]                cur_n;
    logic                      base_in_q;
    logic                      cur_base_in;

    function automatic thumb_ctrl_pkg::reg_addr_t lowest_reg(
        input thumb_ctrl_pkg::reg_list_t list
    );
        thumb_ctrl_pkg::reg_addr_t idx;
        idx = '0;
        for (int i = 15; i >= 0; i--) begin
            if (list[i]) begin
                idx = thumb_ctrl_pkg::reg_addr_t'(i);
            end
        end
        return idx;
    endfunction

    assign pop_o = (state_q == ST_IDLE) && !empty_i;

    always_comb begin
        // in idle the head of the queue is the instruction being started
        if (state_q == ST_IDLE) begin
            cur_kind    = head_i.kind;
            cur_tmpl    = head_i.uop;
            cur_list    = head_i.reg_list;
            cur_base    = head_i.base;
            cur_k       = '0;
            cur_n       = 5'($countones(head_i.reg_list));
            cur_base_in = head_i.reg_list[head_i.base];
        end else begin
            cur_kind    = kind_q;
            cur_tmpl    = tmpl_q;
            cur_list    = list_q;
            cur_base    = base_q;
            cur_k       = k_q;
            cur_n       = n_q;
            cur_base_in = base_in_q;
        end
        low_reg   = lowest_reg(cur_list);
        rest_list = cur_list & (cur_list - 16'd1);

        word_d  = '0;
        state_d = state_q;
        if (state_q != ST_IDLE || !empty_i) begin
            if (cur_kind == thumb_ctrl_pkg::KIND_SINGLE) begin
                word_d  = cur_tmpl;
                state_d = ST_IDLE;
            end else begin
                word_d.alu_op   = cur_tmpl.alu_op;
                word_d.src1_sel = cur_tmpl.src1_sel;
                word_d.src2_sel = cur_tmpl.src2_sel;
                word_d.rn       = cur_base;
                if (cur_list != '0) begin
                    state_d = (rest_list != '0) ? ST_TRANSFER : ST_FINAL;
                    // push stores below SP, so its offsets fall as k rises
                    if (cur_kind == thumb_ctrl_pkg::KIND_PUSH) begin
                        word_d.imm = thumb_ctrl_pkg::word_t'(
                            thumb_ctrl_pkg::WORD_BYTES * (cur_n - cur_k));
                    end else begin
                        word_d.imm = thumb_ctrl_pkg::word_t'(
                            thumb_ctrl_pkg::WORD_BYTES * cur_k);
                    end
                    if (cur_kind == thumb_ctrl_pkg::KIND_LDM) begin
                        word_d.mem_re = 1'b1;
                        word_d.reg_we = 1'b1;
                        word_d.wb_sel = thumb_ctrl_pkg::WB_MEM;
                        word_d.rd     = low_reg;
                    end else begin
                        word_d.mem_we = 1'b1;
                        word_d.rm     = low_reg;
                    end
                end else begin
                    state_d    = ST_IDLE;
                    word_d.rd  = cur_base;
                    word_d.imm = thumb_ctrl_pkg::word_t'(thumb_ctrl_pkg::WORD_BYTES * cur_n);
                    // a loaded base keeps its loaded value
                    word_d.reg_we = (cur_kind != thumb_ctrl_pkg::KIND_LDM) || !cur_base_in;
                end
            end
            word_d.valid = 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q    <= ST_IDLE;
            micro_op_o <= '0;
        end else begin
            state_q    <= state_d;
            micro_op_o <= word_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (pop_o) begin
            kind_q    <= head_i.kind;
            tmpl_q    <= head_i.uop;
            base_q    <= head_i.base;
            n_q       <= cur_n;
            base_in_q <= cur_base_in;
        end
        list_q <= rest_list;
        k_q    <= cur_k + 5'd1;
    end

    // nothing leaves the queue while a register list is still being expanded
    a_no_pop_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        pop_o && (head_i.kind != thumb_ctrl_pkg::KIND_SINGLE) &&
        (head_i.reg_list != '0) |=> !pop_o);

endmodule

//--- logic/thumb_ctrl_top.sv
`timescale 1ns/1ps

module thumb_ctrl_top #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      instr_valid_i,
    input  thumb_ctrl_pkg::instr_t    instr_i,
    output thumb_ctrl_pkg::micro_op_t micro_op_o,
    output logic                      illegal_o,
    output logic                      queue_full_o
);

    logic                        push;
    thumb_ctrl_pkg::decoded_op_t push_data;
    thumb_ctrl_pkg::decoded_op_t head;
    logic                        empty;
    logic                        pop;

    thumb_decoder i_decoder (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .push_o        (push),
        .push_data_o   (push_data),
        .illegal_o     (illegal_o)
    );

    micro_op_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) i_queue (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .push_i      (push),
        .push_data_i (push_data),
        .pop_i       (pop),
        .head_o      (head),
        .empty_o     (empty),
        .full_o      (queue_full_o)
    );

    reg_list_sequencer i_sequencer (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .head_i     (head),
        .empty_i    (empty),
        .pop_o      (pop),
        .micro_op_o (micro_op_o)
    );

endmodule

//--- verification/thumb_ctrl_model.svh
// expected control words, worked out from the instruction encodings

function automatic logic is_legal_instr(input thumb_ctrl_pkg::instr_t instr);
    return (instr[15:14] == 2'b00) || (instr[15:10] == 6'b010000) ||
        (instr[15:9] == 7'b1011010) || (instr[15:12] == 4'b1100);
endfunction

function automatic thumb_ctrl_pkg::micro_op_t single_word(input thumb_ctrl_pkg::instr_t instr);
    thumb_ctrl_pkg::micro_op_t w;
    w = '0;
    w.valid = 1'b1;
    w.update_flags = 1'b1;
    w.reg_we = 1'b1;
    if (instr[15:13] == 3'b001) begin
        // move, compare, add and subtract with an 8-bit immediate
        w.rd = {1'b0, instr[10:8]};
        w.rn = w.rd;
        w.imm = thumb_ctrl_pkg::word_t'(instr[7:0]);
        w.src2_sel = thumb_ctrl_pkg::SEL_IMM;
        if (instr[11]) w.alu_op = thumb_ctrl_pkg::ALU_SUB;
        if (instr[12:11] == 2'b00) w.src1_sel = thumb_ctrl_pkg::SEL_ZERO;
        if (instr[12:11] == 2'b01) w.reg_we = 1'b0;
    end else if (instr[15:14] == 2'b00) begin
        w.rd = {1'b0, instr[2:0]};
        w.rn = {1'b0, instr[5:3]};
        if (instr[12:11] == 2'b11) begin
            if (instr[9]) w.alu_op = thumb_ctrl_pkg::ALU_SUB;
            if (instr[10]) begin
                w.imm = thumb_ctrl_pkg::word_t'(instr[8:6]);
                w.src2_sel = thumb_ctrl_pkg::SEL_IMM;
            end else begin
                w.rm = {1'b0, instr[8:6]};
            end
        end else begin
            w.alu_op = (instr[12:11] == 2'b00) ? thumb_ctrl_pkg::ALU_LSL :
                (instr[12:11] == 2'b01) ? thumb_ctrl_pkg::ALU_LSR : thumb_ctrl_pkg::ALU_ASR;
            w.imm = thumb_ctrl_pkg::word_t'(instr[10:6]);
            w.src2_sel = thumb_ctrl_pkg::SEL_IMM;
        end
    end else begin
        w.rd = {1'b0, instr[2:0]};
        w.rn = w.rd;
        w.rm = {1'b0, instr[5:3]};
        case (instr[9:6])
            4'd0, 4'd8: w.alu_op = thumb_ctrl_pkg::ALU_AND;
            4'd1:       w.alu_op = thumb_ctrl_pkg::ALU_XOR;
            4'd2:       w.alu_op = thumb_ctrl_pkg::ALU_LSL;
            4'd3:       w.alu_op = thumb_ctrl_pkg::ALU_LSR;
            4'd4:       w.alu_op = thumb_ctrl_pkg::ALU_ASR;
            4'd5, 4'd11: w.alu_op = thumb_ctrl_pkg::ALU_ADD;
            4'd6, 4'd9, 4'd10: w.alu_op = thumb_ctrl_pkg::ALU_SUB;
            4'd7:       w.alu_op = thumb_ctrl_pkg::ALU_ROTATE_R;
            4'd12:      w.alu_op = thumb_ctrl_pkg::ALU_OR;
            4'd13:      w.alu_op = thumb_ctrl_pkg::ALU_MULT;
            4'd14:      w.alu_op = thumb_ctrl_pkg::ALU_BIT_CLEAR;
            default:    w.alu_op = thumb_ctrl_pkg::ALU_NOT;
        endcase
        // test, compare and compare-negative only set flags
        if (instr[9:6] inside {4'd8, 4'd10, 4'd11}) w.reg_we = 1'b0;
        if (instr[9:6] == 4'd9) w.src1_sel = thumb_ctrl_pkg::SEL_ZERO;
    end
    return w;
endfunction

// a negative register number asks for the closing base-update word
function automatic thumb_ctrl_pkg::micro_op_t list_word(
    input thumb_ctrl_pkg::op_kind_e kind, input thumb_ctrl_pkg::reg_addr_t base,
    input int r, input int k, input int n, input logic base_in
);
    thumb_ctrl_pkg::micro_op_t w;
    w = '0;
    w.valid = 1'b1;
    w.src2_sel = thumb_ctrl_pkg::SEL_IMM;
    w.rn = base;
    if (kind == thumb_ctrl_pkg::KIND_PUSH) w.alu_op = thumb_ctrl_pkg::ALU_SUB;
    if (r < 0) begin
        w.rd = base;
        w.imm = thumb_ctrl_pkg::word_t'(thumb_ctrl_pkg::WORD_BYTES * n);
        w.reg_we = !(kind == thumb_ctrl_pkg::KIND_LDM && base_in);
    end else if (kind == thumb_ctrl_pkg::KIND_LDM) begin
        w.rd = thumb_ctrl_pkg::reg_addr_t'(r);
        w.imm = thumb_ctrl_pkg::word_t'(thumb_ctrl_pkg::WORD_BYTES * k);
        w.mem_re = 1'b1;
        w.reg_we = 1'b1;
        w.wb_sel = thumb_ctrl_pkg::WB_MEM;
    end else begin
        w.rm = thumb_ctrl_pkg::reg_addr_t'(r);
        w.mem_we = 1'b1;
        w.imm = (kind == thumb_ctrl_pkg::KIND_PUSH) ?
            thumb_ctrl_pkg::word_t'(thumb_ctrl_pkg::WORD_BYTES * (n - k)) :
            thumb_ctrl_pkg::word_t'(thumb_ctrl_pkg::WORD_BYTES * k);
    end
    return w;
endfunction

//--- verification/tb_thumb_ctrl.sv
`timescale 1ns/1ps

module tb_thumb_ctrl;

    localparam int RESET_CYCLES  = 5;
    localparam int RANDOM_INSTRS = 200;
    localparam int QUEUE_DEPTH   = 4;
    // push empty, LR only and full, then store/load lists with and without the base
    localparam thumb_ctrl_pkg::instr_t LIST_CASES [9] = '{
        16'hB400, 16'hB500, 16'hB5FF, 16'hC000, 16'hC0FF,
        16'hCAFF, 16'hCB07, 16'hD000, 16'hBC01
    };

    logic                      clk_i;
    logic                      rst_n_i;
    logic                      instr_valid_i;
    thumb_ctrl_pkg::instr_t    instr_i;
    thumb_ctrl_pkg::micro_op_t micro_op_o;
    logic                      illegal_o;
    logic                      queue_full_o;

    thumb_ctrl_pkg::micro_op_t exp_q [$];
    logic                      first_q [$];
    integer                    seed;
    int                        error_count;
    int                        neg_count;
    int                        latency_due;
    int                        queued;
    int                        cycle_count;
    int                        cycle_limit = 2 * RESET_CYCLES + 20;
    logic                      exp_illegal;

    `include "thumb_ctrl_model.svh"

    thumb_ctrl_top #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) i_dut (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .micro_op_o    (micro_op_o),
        .illegal_o     (illegal_o),
        .queue_full_o  (queue_full_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    // the limit grows with every instruction and idle gap that is issued
    initial begin
        cycle_count = 0;
        while (cycle_count <= cycle_limit) begin
            @(posedge clk_i);
            cycle_count++;
        end
        $display("timeout: the run went past its limit of %0d cycles", cycle_limit);
        $display("=== FAIL ===");
        $finish;
    end

    task automatic check_outputs();
        thumb_ctrl_pkg::micro_op_t exp_word;
        if (illegal_o !== exp_illegal) begin
            error_count++;
            $display("** Error at %0t ns: illegal_o = %b, expected %b",
                $time, illegal_o, exp_illegal);
        end
        if ((neg_count == latency_due - 1 && micro_op_o.valid) ||
            (neg_count == latency_due && micro_op_o.valid !== 1'b1)) begin
            error_count++;
            $display("at %0t ns the first word of an instruction sent to the idle design %s",
                $time, "did not come exactly one cycle after the strobe");
        end
        if (micro_op_o.valid) begin
            if (exp_q.size() == 0) begin
                error_count++;
                $display("at %0t ns a word came out that no instruction should produce", $time);
            end else begin
                exp_word = exp_q.pop_front();
                // the first word of an instruction shows that it has left the queue
                if (first_q.pop_front()) begin
                    queued--;
                end
                if (micro_op_o !== exp_word) begin
                    error_count++;
                    $display("** Error at %0t ns: micro_op_o = %h, expected %h",
                        $time, micro_op_o, exp_word);
                end
            end
        end
        if (queue_full_o !== (queued == QUEUE_DEPTH)) begin
            error_count++;
            $display("** Error at %0t ns: queue_full_o = %b, expected %b",
                $time, queue_full_o, queued == QUEUE_DEPTH);
        end
    endtask

    task automatic next_cycle();
        @(negedge clk_i);
        neg_count++;
        check_outputs();
        instr_valid_i = 1'b0;
        exp_illegal = 1'b0;
    endtask

    task automatic idle_cycles(input int n);
        cycle_limit += 2 * n;
        repeat (n) next_cycle();
    endtask

    task automatic expect_words(input thumb_ctrl_pkg::instr_t instr);
        thumb_ctrl_pkg::op_kind_e  kind;
        thumb_ctrl_pkg::reg_list_t list;
        thumb_ctrl_pkg::reg_addr_t base;
        int                        n;
        int                        k;
        if (instr[15:12] != 4'hB && instr[15:12] != 4'hC) begin
            exp_q.push_back(single_word(instr));
            first_q.push_back(1'b1);
            cycle_limit += 2;
        end else begin
            kind = (instr[15:12] == 4'hB) ? thumb_ctrl_pkg::KIND_PUSH :
                (instr[11] ? thumb_ctrl_pkg::KIND_LDM : thumb_ctrl_pkg::KIND_STM);
            list = (kind == thumb_ctrl_pkg::KIND_PUSH) ?
                {1'b0, instr[8], 6'b0, instr[7:0]} : {8'b0, instr[7:0]};
            base = (kind == thumb_ctrl_pkg::KIND_PUSH) ?
                thumb_ctrl_pkg::SP_REG : {1'b0, instr[10:8]};
            n = 0;
            for (int r = 0; r < 16; r++) n += int'(list[r]);
            k = 0;
            for (int r = 0; r < 16; r++) begin
                if (list[r]) begin
                    exp_q.push_back(list_word(kind, base, r, k, n, 1'b0));
                    first_q.push_back(k == 0);
                    k++;
                end
            end
            exp_q.push_back(list_word(kind, base, -1, k, n, list[base]));
            first_q.push_back(k == 0);
            cycle_limit += 2 * (n + 1);
        end
    endtask

    task automatic send_instr(input thumb_ctrl_pkg::instr_t instr);
        while (queue_full_o) next_cycle();
        if (is_legal_instr(instr)) begin
            // nothing in flight means queue and sequencer are both idle
            if (exp_q.size() == 0) latency_due = neg_count + 2;
            expect_words(instr);
            queued++;
        end else begin
            exp_illegal = 1'b1;
            cycle_limit += 2;
        end
        instr_i = instr;
        instr_valid_i = 1'b1;
        next_cycle();
    endtask

    function automatic thumb_ctrl_pkg::instr_t random_instr();
        logic [31:0] rnd;
        rnd = $random(seed);
        case (rnd[18:16])
            3'd0, 3'd1: return {2'b00, rnd[13:0]};
            3'd2, 3'd3: return {6'b010000, rnd[9:0]};
            3'd4:       return {7'b1011010, rnd[8:0]};
            3'd5, 3'd6: return {4'b1100, rnd[11:0]};
            default: begin
                // hi-register, load/store, pop and branch encodings
                case (rnd[15:14])
                    2'd0:    return {6'b010001, rnd[9:0]};
                    2'd1:    return {4'b0101, rnd[11:0]};
                    2'd2:    return {7'b1011110, rnd[8:0]};
                    default: return {4'b1101, rnd[11:0]};
                endcase
            end
        endcase
    endfunction

    initial begin : main_seq
        logic [31:0] rnd;
        logic [6:0]  reset_bits;
        seed = 32'hf3fe_9de7;
        rst_n_i = 1'b0;
        instr_valid_i = 1'b0;
        instr_i = '0;
        exp_illegal = 1'b0;
        error_count = 0;
        neg_count = 0;
        queued = 0;
        latency_due = -10;
        repeat (RESET_CYCLES) @(negedge clk_i);
        reset_bits = {micro_op_o.valid, micro_op_o.update_flags, micro_op_o.reg_we,
            micro_op_o.mem_we, micro_op_o.mem_re, illegal_o, queue_full_o};
        if (reset_bits !== 7'b0) begin
            error_count++;
            $display("** Error at %0t ns: reset outputs = %b, expected %b",
                $time, reset_bits, 7'b0);
        end
        rst_n_i = 1'b1;

        // the last four cover the register and 3-bit immediate add/sub forms
        for (int i = 0; i < 12; i++) begin
            rnd = $random(seed);
            send_instr((i < 8) ? {2'b00, i[2:0], rnd[10:0]} : {5'b00011, i[1:0], rnd[8:0]});
        end
        for (int i = 0; i < 16; i++) begin
            rnd = $random(seed);
            send_instr({6'b010000, i[3:0], rnd[5:0]});
        end
        for (int i = 0; i < 9; i++) send_instr(LIST_CASES[i]);
        while (exp_q.size() != 0) next_cycle();
        send_instr(16'h2105);

        for (int i = 0; i < RANDOM_INSTRS; i++) begin
            send_instr(random_instr());
            rnd = $random(seed);
            if (rnd[1:0] == 2'b00) idle_cycles(1 + int'(rnd[3:2]));
        end
        while (exp_q.size() != 0) next_cycle();
        idle_cycles(4);

        $display("errors: %0d, words still expected: %0d", error_count, exp_q.size());
        if (error_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- compile.f
+incdir+verification
logic/thumb_ctrl_pkg.sv
logic/thumb_decoder.sv
logic/micro_op_queue.sv
logic/reg_list_sequencer.sv
logic/thumb_ctrl_top.sv
verification/tb_thumb_ctrl.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f --top-module tb_thumb_ctrl \
    -Mdir obj_dir -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -qx "=== PASS ===" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
